// ==== src/ooo_pkg.sv ====
package ooo_pkg;

    // Datapath width and shift amount width
    localparam int XLEN = 32;
    localparam int SHAMT_W = $clog2(XLEN);

    // ROB tag space
    localparam int ROB_ENTRIES = 8;
    localparam int ROB_TAG_W = $clog2(ROB_ENTRIES);

    // Station entries, one ALU each
    localparam int RS_ENTRIES = 4;
    localparam int RS_IDX_W = $clog2(RS_ENTRIES);

    // RV32I integer operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // One source operand
    // Value is meaningful only once ready is set, otherwise tag names the producer
    typedef struct packed {
        logic                 ready;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      value;
    } operand_t;

    // One operation as handed over at dispatch
    typedef struct packed {
        alu_op_t              op;
        operand_t             src1;
        operand_t             src2;
        logic [ROB_TAG_W-1:0] dest;
    } alu_dispatch_t;

    // One result broadcast on the common data bus
    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      value;
    } cdb_entry_t;

endpackage

// ==== src/alu.sv ====
module alu (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          flush_i,
    input  logic                          start_i,
    input  ooo_pkg::alu_op_t              op_i,
    input  logic [ooo_pkg::XLEN-1:0]      a_i,
    input  logic [ooo_pkg::XLEN-1:0]      b_i,
    input  logic [ooo_pkg::ROB_TAG_W-1:0] dest_i,
    input  logic                          grant_i,
    output ooo_pkg::cdb_entry_t           result_o
);
    import ooo_pkg::*;

    logic [XLEN-1:0]    alu_out;
    logic [SHAMT_W-1:0] shamt;

    // Shifts only look at the low bits of the second operand
    assign shamt = b_i[SHAMT_W-1:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  alu_out = a_i + b_i;
            ALU_SUB:  alu_out = a_i - b_i;
            ALU_SLL:  alu_out = a_i << shamt;
            ALU_SLT:  alu_out = XLEN'($signed(a_i) < $signed(b_i));
            ALU_SLTU: alu_out = XLEN'(a_i < b_i);
            ALU_XOR:  alu_out = a_i ^ b_i;
            ALU_SRL:  alu_out = a_i >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:  alu_out = $signed(a_i) >>> shamt;
            ALU_OR:   alu_out = a_i | b_i;
            ALU_AND:  alu_out = a_i & b_i;
            default:  alu_out = '0;
        endcase
    end

    // Request flag, raised at issue and dropped once the arbiter takes it
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            result_o.valid <= 1'b0;
        end else if (start_i) begin
            result_o.valid <= 1'b1;
        end else if (grant_i) begin
            result_o.valid <= 1'b0;
        end
    end

    // Result payload, held until the next issue
    always_ff @(posedge clk) begin
        if (start_i) begin
            result_o.tag   <= dest_i;
            result_o.value <= alu_out;
        end
    end

endmodule

// ==== src/rob_result_table.sv ====
module rob_result_table (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          flush_i,
    input  ooo_pkg::cdb_entry_t           cdb_i,
    input  logic                          alloc_valid_i,
    input  logic [ooo_pkg::ROB_TAG_W-1:0] alloc_tag_i,
    input  logic [ooo_pkg::ROB_TAG_W-1:0] lookup1_tag_i,
    input  logic [ooo_pkg::ROB_TAG_W-1:0] lookup2_tag_i,
    output logic                          lookup1_done_o,
    output logic [ooo_pkg::XLEN-1:0]      lookup1_value_o,
    output logic                          lookup2_done_o,
    output logic [ooo_pkg::XLEN-1:0]      lookup2_value_o
);
    import ooo_pkg::*;

    // One done flag per ROB tag
    logic [ROB_ENTRIES-1:0] done_q;

    // Last broadcast value per ROB tag
    logic [XLEN-1:0] value_q [ROB_ENTRIES];

    // Done flags
    // A broadcast marks its tag complete
    // A new allocation of the same tag is written last so it wins
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            done_q <= '0;
        end else begin
            if (cdb_i.valid) begin
                done_q[cdb_i.tag] <= 1'b1;
            end
            if (alloc_valid_i) begin
                done_q[alloc_tag_i] <= 1'b0;
            end
        end
    end

    // Value store, written on every broadcast
    always_ff @(posedge clk) begin
        if (cdb_i.valid) begin
            value_q[cdb_i.tag] <= cdb_i.value;
        end
    end

    // Dispatch lookups are combinational
    // Same-cycle broadcasts are bypassed in the station, not here
    assign lookup1_done_o  = done_q[lookup1_tag_i];
    assign lookup1_value_o = value_q[lookup1_tag_i];
    assign lookup2_done_o  = done_q[lookup2_tag_i];
    assign lookup2_value_o = value_q[lookup2_tag_i];

endmodule

// ==== src/cdb_arbiter.sv ====
module cdb_arbiter (
    input  logic                                          clk,
    input  logic                                          reset_i,
    input  logic                                          flush_i,
    input  ooo_pkg::cdb_entry_t [ooo_pkg::RS_ENTRIES-1:0] req_i,
    input  logic                                          cdb_ready_i,
    output ooo_pkg::cdb_entry_t                           cdb_o,
    output logic [ooo_pkg::RS_ENTRIES-1:0]                grant_o
);
    import ooo_pkg::*;

    // Round-robin start point
    logic [RS_IDX_W-1:0] ptr_q;

    // Search state
    logic [RS_IDX_W-1:0] cand_idx;
    logic [RS_IDX_W-1:0] win_idx;
    logic [RS_IDX_W-1:0] next_idx;
    logic                win_found;

    // First valid request at or after the pointer, wrapping around
    always_comb begin
        win_found = 1'b0;
        win_idx   = '0;
        cand_idx  = '0;
        for (int k = 0; k < RS_ENTRIES; k++) begin
            cand_idx = RS_IDX_W'((int'(ptr_q) + k) % RS_ENTRIES);
            if (!win_found && req_i[cand_idx].valid) begin
                win_found = 1'b1;
                win_idx   = cand_idx;
            end
        end
    end

    assign next_idx = RS_IDX_W'((int'(win_idx) + 1) % RS_ENTRIES);

    // Winner goes straight onto the bus
    assign cdb_o = win_found ? req_i[win_idx] : '0;

    // Grant only on an actual transfer
    always_comb begin
        grant_o = '0;
        if (win_found && cdb_ready_i) begin
            grant_o[win_idx] = 1'b1;
        end
    end

    // Pointer update
    // On a stall the pointer parks on the winner, so the bus holds the same entry
    // On a transfer it moves one past the winner
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ptr_q <= '0;
        end else if (win_found) begin
            if (cdb_ready_i) begin
                ptr_q <= next_idx;
            end else begin
                ptr_q <= win_idx;
            end
        end
    end

endmodule

// ==== src/alu_rs.sv ====
module alu_rs (
    input  logic                                          clk,
    input  logic                                          reset_i,
    input  logic                                          flush_i,

    // Dispatch handshake
    input  logic                                          dispatch_valid_i,
    input  ooo_pkg::alu_dispatch_t                        dispatch_i,
    output logic                                          dispatch_ready_o,

    // Result table lookup for the dispatched sources
    output logic [ooo_pkg::ROB_TAG_W-1:0]                 lookup1_tag_o,
    input  logic                                          lookup1_done_i,
    input  logic [ooo_pkg::XLEN-1:0]                      lookup1_value_i,
    output logic [ooo_pkg::ROB_TAG_W-1:0]                 lookup2_tag_o,
    input  logic                                          lookup2_done_i,
    input  logic [ooo_pkg::XLEN-1:0]                      lookup2_value_i,

    // Destination tag being allocated
    output logic                                          alloc_valid_o,
    output logic [ooo_pkg::ROB_TAG_W-1:0]                 alloc_tag_o,

    // Broadcast, valid only on a bus transfer
    input  ooo_pkg::cdb_entry_t                           cdb_i,

    // ALU results towards the arbiter and its grants back
    output ooo_pkg::cdb_entry_t [ooo_pkg::RS_ENTRIES-1:0] alu_req_o,
    input  logic [ooo_pkg::RS_ENTRIES-1:0]                cdb_grant_i
);
    import ooo_pkg::*;

    // Entry control state
    logic [RS_ENTRIES-1:0] busy_q;
    // Set from issue until grant, so it also marks the ALU as occupied
    logic [RS_ENTRIES-1:0] issued_q;

    // Entry payload: opcode, both sources and the destination tag
    alu_dispatch_t slot_q [RS_ENTRIES];

    // Dispatch side
    alu_dispatch_t       new_entry;
    logic                dispatch_fire;
    logic                free_found;
    logic [RS_IDX_W-1:0] alloc_idx;

    // Per-entry issue strobe
    logic [RS_ENTRIES-1:0] start;

    // Capture a matching broadcast into a waiting source
    function automatic operand_t snoop(operand_t src, cdb_entry_t bus);
        operand_t res;
        res = src;
        if (!src.ready && bus.valid && bus.tag == src.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    // Dispatch resolution
    // Same-cycle broadcast first, then a value already in the result table
    function automatic operand_t resolve(
        operand_t        src,
        cdb_entry_t      bus,
        logic            done,
        logic [XLEN-1:0] value
    );
        operand_t res;
        res = snoop(src, bus);
        if (!res.ready && done) begin
            res.ready = 1'b1;
            res.value = value;
        end
        return res;
    endfunction

    // Ready only needs one free entry
    assign dispatch_ready_o = ~(&busy_q);
    assign dispatch_fire    = dispatch_valid_i && dispatch_ready_o;

    // Table lookups use the incoming source tags directly
    assign lookup1_tag_o = dispatch_i.src1.tag;
    assign lookup2_tag_o = dispatch_i.src2.tag;

    // Accepted destination tag clears its done flag
    assign alloc_valid_o = dispatch_fire;
    assign alloc_tag_o   = dispatch_i.dest;

    // Lowest free entry
    always_comb begin
        free_found = 1'b0;
        alloc_idx  = '0;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (!free_found && !busy_q[i]) begin
                free_found = 1'b1;
                alloc_idx  = RS_IDX_W'(i);
            end
        end
    end

    // Incoming operation with its sources resolved as far as possible
    always_comb begin
        new_entry      = dispatch_i;
        new_entry.src1 = resolve(dispatch_i.src1, cdb_i, lookup1_done_i, lookup1_value_i);
        new_entry.src2 = resolve(dispatch_i.src2, cdb_i, lookup2_done_i, lookup2_value_i);
    end

    // Issue once both sources are known and the ALU is free
    always_comb begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            start[i] = busy_q[i] && !issued_q[i]
                    && slot_q[i].src1.ready && slot_q[i].src2.ready;
        end
    end

    // Busy and issued flags
    // Entry is released at its grant edge and is reusable the next cycle
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            busy_q   <= '0;
            issued_q <= '0;
        end else begin
            for (int i = 0; i < RS_ENTRIES; i++) begin
                if (start[i]) begin
                    issued_q[i] <= 1'b1;
                end
                if (cdb_grant_i[i]) begin
                    busy_q[i]   <= 1'b0;
                    issued_q[i] <= 1'b0;
                end
                // Only a free entry is allocated, so this never meets a grant
                if (dispatch_fire && alloc_idx == RS_IDX_W'(i)) begin
                    busy_q[i]   <= 1'b1;
                    issued_q[i] <= 1'b0;
                end
            end
        end
    end

    // Payload
    // Either the new operation, or the old one with both sources snooping the bus
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (dispatch_fire && alloc_idx == RS_IDX_W'(i)) begin
                slot_q[i] <= new_entry;
            end else begin
                slot_q[i].src1 <= snoop(slot_q[i].src1, cdb_i);
                slot_q[i].src2 <= snoop(slot_q[i].src2, cdb_i);
            end
        end
    end

    // One ALU per entry
    for (genvar g = 0; g < RS_ENTRIES; g++) begin : g_alu
        alu u_alu (
            .clk      (clk),
            .reset_i  (reset_i),
            .flush_i  (flush_i),
            .start_i  (start[g]),
            .op_i     (slot_q[g].op),
            .a_i      (slot_q[g].src1.value),
            .b_i      (slot_q[g].src2.value),
            .dest_i   (slot_q[g].dest),
            .grant_i  (cdb_grant_i[g]),
            .result_o (alu_req_o[g])
        );
    end

endmodule

// ==== src/alu_cluster.sv ====
module alu_cluster (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   flush_i,
    input  logic                   dispatch_valid_i,
    input  ooo_pkg::alu_dispatch_t dispatch_i,
    output logic                   dispatch_ready_o,
    output ooo_pkg::cdb_entry_t    cdb_o,
    input  logic                   cdb_ready_i
);
    import ooo_pkg::*;

    // Station to result table
    logic [ROB_TAG_W-1:0] lookup1_tag;
    logic [ROB_TAG_W-1:0] lookup2_tag;
    logic                 lookup1_done;
    logic                 lookup2_done;
    logic [XLEN-1:0]      lookup1_value;
    logic [XLEN-1:0]      lookup2_value;
    logic                 alloc_valid;
    logic [ROB_TAG_W-1:0] alloc_tag;

    // Station to arbiter
    cdb_entry_t [RS_ENTRIES-1:0] alu_req;
    logic [RS_ENTRIES-1:0]       cdb_grant;

    // Bus contents qualified by the result port handshake
    // Wakeup and table writes only see completed transfers
    cdb_entry_t cdb_xfer;

    assign cdb_xfer = '{valid: cdb_o.valid && cdb_ready_i, tag: cdb_o.tag, value: cdb_o.value};

    alu_rs u_alu_rs (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .lookup1_tag_o    (lookup1_tag),
        .lookup1_done_i   (lookup1_done),
        .lookup1_value_i  (lookup1_value),
        .lookup2_tag_o    (lookup2_tag),
        .lookup2_done_i   (lookup2_done),
        .lookup2_value_i  (lookup2_value),
        .alloc_valid_o    (alloc_valid),
        .alloc_tag_o      (alloc_tag),
        .cdb_i            (cdb_xfer),
        .alu_req_o        (alu_req),
        .cdb_grant_i      (cdb_grant)
    );

    rob_result_table u_rob_result_table (
        .clk             (clk),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .cdb_i           (cdb_xfer),
        .alloc_valid_i   (alloc_valid),
        .alloc_tag_i     (alloc_tag),
        .lookup1_tag_i   (lookup1_tag),
        .lookup2_tag_i   (lookup2_tag),
        .lookup1_done_o  (lookup1_done),
        .lookup1_value_o (lookup1_value),
        .lookup2_done_o  (lookup2_done),
        .lookup2_value_o (lookup2_value)
    );

    cdb_arbiter u_cdb_arbiter (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .req_i       (alu_req),
        .cdb_ready_i (cdb_ready_i),
        .cdb_o       (cdb_o),
        .grant_o     (cdb_grant)
    );

endmodule

// ==== tests/alu_cluster_tb.sv ====
module alu_cluster_tb;
    import ooo_pkg::*;

    // Operation counts that size the run and the watchdog
    localparam int N_RANDOM = 300;
    localparam int N_OPS = N_RANDOM + 20;
    localparam int DRAIN_CYCLES = 200;

    // Model state of a ROB tag
    localparam int ST_FREE = 0;
    localparam int ST_BUSY = 1;
    localparam int ST_DONE = 2;

    logic          clk;
    logic          reset_i;
    logic          flush_i;
    logic          dispatch_valid_i;
    alu_dispatch_t dispatch_i;
    logic          dispatch_ready_o;
    cdb_entry_t    cdb_o;
    logic          cdb_ready_i;

    // Reference model indexed by destination tag
    int              tag_state [ROB_ENTRIES];
    int              users [ROB_ENTRIES];
    logic [XLEN-1:0] tag_value [ROB_ENTRIES];
    alu_dispatch_t   ops [ROB_ENTRIES];
    int              inflight_cnt;
    logic            accepted_q;

    // Stimulus state
    logic [ROB_TAG_W-1:0] dest_ptr;
    int                   ready_mode;
    logic [31:0]          lfsr = 32'hb99f802b;

    alu_cluster uut (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .cdb_o            (cdb_o),
        .cdb_ready_i      (cdb_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic void stop_on_error(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Expected result from the RV32I rules
    function automatic logic [XLEN-1:0] ref_alu(alu_op_t op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] ext;
        // Sign-extended copy so a logical shift gives the arithmetic one
        ext = {{XLEN{a[XLEN-1]}}, a} >> b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            // Differing signs decide by the sign of a alone
            ALU_SLT:  return (a[31] != b[31]) ? XLEN'(a[31]) : XLEN'(a < b);
            ALU_SLTU: return XLEN'(a < b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return ext[XLEN-1:0];
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return 'x;
        endcase
    endfunction

    function automatic operand_t imm(logic [XLEN-1:0] v);
        operand_t r;
        r.ready = 1'b1;
        r.tag   = '0;
        r.value = v;
        return r;
    endfunction

    // Junk value field that the DUT must never use
    function automatic operand_t from_tag(logic [ROB_TAG_W-1:0] t);
        operand_t r;
        r.ready = 1'b0;
        r.tag   = t;
        r.value = '1;
        return r;
    endfunction

    function automatic void clear_model();
        for (int t = 0; t < ROB_ENTRIES; t++) begin
            tag_state[t] = ST_FREE;
            users[t]     = 0;
        end
        inflight_cnt = 0;
    endfunction

    function automatic void accept(alu_dispatch_t d);
        tag_state[d.dest] = ST_BUSY;
        ops[d.dest]       = d;
        inflight_cnt++;
        if (!d.src1.ready) begin
            users[d.src1.tag]++;
        end
        if (!d.src2.ready) begin
            users[d.src2.tag]++;
        end
    endfunction

    // Tag sources must already have been broadcast
    function automatic logic [XLEN-1:0] source_value(logic [ROB_TAG_W-1:0] dest, operand_t s);
        if (s.ready) begin
            return s.value;
        end
        assert (tag_state[s.tag] == ST_DONE)
            else stop_on_error($sformatf("Error: cdb_o.tag %h broadcast before source tag %h",
                                         dest, s.tag));
        return tag_value[s.tag];
    endfunction

    function automatic void retire(cdb_entry_t c);
        alu_dispatch_t   o;
        logic [XLEN-1:0] exp;
        assert (tag_state[c.tag] == ST_BUSY)
            else stop_on_error($sformatf("Error: cdb_o.tag %h is not in flight", c.tag));
        o   = ops[c.tag];
        exp = ref_alu(o.op, source_value(c.tag, o.src1), source_value(c.tag, o.src2));
        assert (c.value == exp)
            else stop_on_error($sformatf("Error: cdb_o.value for tag %h expected %h got %h",
                                         c.tag, exp, c.value));
        tag_state[c.tag] = ST_DONE;
        tag_value[c.tag] = exp;
        inflight_cnt--;
        if (!o.src1.ready) begin
            users[o.src1.tag]--;
        end
        if (!o.src2.ready) begin
            users[o.src2.tag]--;
        end
    endfunction

    // Model samples the DUT at each rising edge before its registers update
    always @(posedge clk) begin
        accepted_q = 1'b0;
        if (reset_i || flush_i) begin
            clear_model();
        end else begin
            // One entry per in-flight operation until its broadcast
            assert (dispatch_ready_o == (inflight_cnt < RS_ENTRIES))
                else stop_on_error($sformatf("Error: dispatch_ready_o expected %h got %h",
                                             inflight_cnt < RS_ENTRIES, dispatch_ready_o));
            if (cdb_o.valid && cdb_ready_i) begin
                retire(cdb_o);
            end
            if (dispatch_valid_i && dispatch_ready_o) begin
                accept(dispatch_i);
                accepted_q = 1'b1;
            end
        end
    end

    // A stalled broadcast stays put
    a_hold: assert property (@(posedge clk) disable iff (reset_i)
                             cdb_o.valid && !cdb_ready_i && !flush_i |=> $stable(cdb_o))
        else stop_on_error($sformatf("Error: cdb_o changed under back-pressure, now %h", cdb_o));

    // Flush leaves an idle bus and an empty station
    a_flush: assert property (@(posedge clk) disable iff (reset_i)
                              flush_i |=> !cdb_o.valid && dispatch_ready_o)
        else stop_on_error($sformatf("Error: after flush cdb_o.valid %h dispatch_ready_o %h",
                                     cdb_o.valid, dispatch_ready_o));

    initial begin
        repeat (N_OPS * 40) @(posedge clk);
        stop_on_error("Timeout: the operations did not complete within the watchdog limit");
    end

    // Advance to the next falling edge and drive cdb_ready_i low, high or random
    task automatic tick();
        @(negedge clk);
        case (ready_mode)
            0:       cdb_ready_i = 1'b0;
            1:       cdb_ready_i = 1'b1;
            default: cdb_ready_i = (take_bits(2) != 2'd0);
        endcase
    endtask

    // Tag that is not in flight, has no waiting consumer and is no source here
    function automatic logic pick_dest(operand_t s1, operand_t s2,
                                       output logic [ROB_TAG_W-1:0] d);
        for (int k = 0; k < ROB_ENTRIES; k++) begin
            d = dest_ptr + ROB_TAG_W'(k);
            if (tag_state[d] != ST_BUSY && users[d] == 0
                    && !(!s1.ready && s1.tag == d) && !(!s2.ready && s2.tag == d)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Hold the operation on the port until it is accepted
    task automatic send(alu_op_t op, operand_t s1, operand_t s2,
                        output logic [ROB_TAG_W-1:0] d);
        logic got;
        got = 1'b0;
        while (!got) begin
            dispatch_valid_i = pick_dest(s1, s2, d);
            dispatch_i       = '{op: op, src1: s1, src2: s2, dest: d};
            tick();
            got = dispatch_valid_i && accepted_q;
        end
        dispatch_valid_i = 1'b0;
        dest_ptr         = d + 1'b1;
    endtask

    // Immediate or a tag that has been dispatched
    function automatic operand_t random_src();
        operand_t             r;
        logic [ROB_TAG_W-1:0] t;
        r = imm(take_bits(32));
        if (take_bits(1) == 1'b1) begin
            t = ROB_TAG_W'(take_bits(3));
            for (int k = 0; k < ROB_ENTRIES; k++) begin
                if (r.ready && tag_state[t] != ST_FREE) begin
                    r = from_tag(t);
                end
                t = t + 1'b1;
            end
        end
        return r;
    endfunction

    task automatic wait_drain();
        int n;
        n = 0;
        while (inflight_cnt != 0 && n < DRAIN_CYCLES) begin
            tick();
            n++;
        end
    endtask

    initial begin
        logic [ROB_TAG_W-1:0] p;
        logic [ROB_TAG_W-1:0] d;
        alu_op_t              op;
        operand_t             s1;
        reset_i          = 1'b1;
        flush_i          = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_i       = '0;
        cdb_ready_i      = 1'b0;
        dest_ptr         = '0;
        ready_mode       = 1;
        repeat (3) @(negedge clk);
        reset_i     = 1'b0;
        cdb_ready_i = 1'b1;

        // Shift edges, signed compare and wrap-around
        send(ALU_SLL, imm(32'h1), imm(32'd31), d);
        send(ALU_SLL, imm(32'h1234_5678), imm(32'd32), d);
        send(ALU_SRL, imm(32'h8000_0000), imm(32'd31), d);
        send(ALU_SRA, imm(32'h8000_0000), imm(32'd31), d);
        send(ALU_SRA, imm(32'h8765_4321), imm(32'd32), d);
        send(ALU_SLT, imm(32'hffff_ffff), imm(32'h1), d);
        send(ALU_SLT, imm(32'h1), imm(32'hffff_ffff), d);
        send(ALU_SLTU, imm(32'hffff_ffff), imm(32'h1), d);
        send(ALU_SUB, imm(32'h0), imm(32'h1), d);
        send(ALU_SUB, imm(32'h8000_0000), imm(32'h1), d);
        wait_drain();
        assert (inflight_cnt == 0) else stop_on_error("Directed operations were never broadcast");

        // Fill all entries behind a stalled producer
        ready_mode  = 0;
        cdb_ready_i = 1'b0;
        send(ALU_ADD, imm(32'h5), imm(32'h7), p);
        for (int i = 0; i < RS_ENTRIES - 1; i++) begin
            send(ALU_XOR, from_tag(p), imm(32'(i)), d);
        end
        tick();
        tick();
        assert (!dispatch_ready_o) else stop_on_error("Error: dispatch_ready_o expected 0 got 1");
        ready_mode  = 1;
        cdb_ready_i = 1'b1;
        wait_drain();
        // Producer finished long ago so its value comes from the result table
        send(ALU_SUB, from_tag(p), imm(32'h1), d);
        wait_drain();
        assert (inflight_cnt == 0) else stop_on_error("Dependent operations were never broadcast");

        // Random traffic with random back-pressure
        ready_mode = 2;
        for (int n = 0; n < N_RANDOM; n++) begin
            if (take_bits(2) == 2'd0) begin
                tick();
            end
            op = alu_op_t'(take_bits(4) % 10);
            s1 = random_src();
            send(op, s1, random_src(), d);
        end
        ready_mode  = 1;
        cdb_ready_i = 1'b1;
        wait_drain();
        assert (inflight_cnt == 0) else stop_on_error("Random operations were never broadcast");

        // Flush a full station holding a finished producer and its waiting consumers
        ready_mode  = 0;
        cdb_ready_i = 1'b0;
        send(ALU_ADD, imm(32'h1), imm(32'h2), p);
        for (int i = 0; i < RS_ENTRIES - 1; i++) begin
            send(ALU_OR, from_tag(p), imm(32'(4 + i)), d);
        end
        repeat (3) tick();
        flush_i = 1'b1;
        tick();
        flush_i     = 1'b0;
        ready_mode  = 1;
        cdb_ready_i = 1'b1;
        repeat (4) tick();
        send(ALU_AND, imm(32'hf0f0_f0f0), imm(32'h3c3c_3c3c), d);
        wait_drain();

        if (inflight_cnt == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_on_error("The operation after the flush was never broadcast");
        end
    end

endmodule

// ==== list.f ====
src/ooo_pkg.sv
src/alu.sv
src/rob_result_table.sv
src/cdb_arbiter.sv
src/alu_rs.sv
src/alu_cluster.sv
tests/alu_cluster_tb.sv
